// ==== hdl/pcie_dma_cfg.svh ====
`ifndef PCIE_DMA_CFG_SVH
`define PCIE_DMA_CFG_SVH

// ************************************************************
// register bus widths.
// ************************************************************
`define PCIE_DATA_W     32
`define PCIE_ADDR_W     8

// ************************************************************
// dma program and status widths.
// ************************************************************
`define DMA_HOST_ADDR_W 64
`define DMA_LEN_W       16
`define DMA_CNT_W       16
`define DMA_PRG_WORDS   4
`define DMA_PRG_IDX_W   2   // word index taken from address bits 3:2.

`endif

// ==== hdl/reg_map_pkg.sv ====
`default_nettype none

package reg_map_pkg;

   // upper address nibble selects the region.
   typedef enum logic [3:0] {
      REG_DMA_WRITE_PRG = 4'h0,
      REG_DMA_READ_PRG  = 4'h1,
      REG_MISC          = 4'h2,
      REG_ERR_STATUS    = 4'h3
   } reg_region_e;

   // lower nibble inside the MISC region.
   typedef enum logic [3:0] {
      WR_STATUS_HI = 4'h0,
      WR_STATUS_LO = 4'h4,
      RD_STATUS_HI = 4'h8,
      RD_STATUS_LO = 4'hC
   } misc_offset_e;

   typedef enum logic [1:0] {
      PRG_ADDR_LO = 2'd0,
      PRG_ADDR_HI = 2'd1,
      PRG_LENGTH  = 2'd2,
      PRG_CONTROL = 2'd3   // bit 0 starts the channel.
   } prg_word_e;

endpackage

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
`default_nettype none

`include "pcie_dma_cfg.svh"

package dma_pkg;

   typedef enum logic [1:0] {
      DMA_IDLE = 2'd0,
      DMA_BUSY = 2'd1,
      DMA_DONE = 2'd2
   } dma_state_e;

   // one write into a program register file.
   typedef struct packed {
      logic                      wrena;
      logic [`DMA_PRG_IDX_W-1:0] word;
      logic [`PCIE_DATA_W-1:0]   data;
   } prg_wr_t;

   typedef struct packed {
      logic [`DMA_HOST_ADDR_W-1:0] host_addr;
      logic [`DMA_LEN_W-1:0]       length;    // in dwords.
   } dma_desc_t;

   // ************************************************************
   // status word, high half first.
   // ************************************************************
   typedef struct packed {
      logic                                busy;
      dma_state_e                          state;
      logic [`PCIE_DATA_W-4-`DMA_CNT_W:0]  pad;
      logic [`DMA_CNT_W-1:0]               done_cnt;
      logic [`PCIE_DATA_W-1:0]             dword_total;
   } dma_status_t;

endpackage

`default_nettype wire

// ==== hdl/ecrc_err_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module ecrc_err_counter (
   input  logic                  clk_in,
   input  logic                  rstn,
   input  logic                  rx_ecrc_bad,
   output logic [`DMA_CNT_W-1:0] bad_cnt
);

   // one count per bad ECRC pulse.
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         bad_cnt <= '0;
      end else if (rx_ecrc_bad && (bad_cnt != '1)) begin
         bad_cnt <= bad_cnt + 1'b1;   // saturates at all ones.
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dma_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module dma_engine (
   input  logic                 clk_in,
   input  logic                 rstn,
   input  logic                 start,
   input  dma_pkg::dma_desc_t   desc,
   output dma_pkg::dma_status_t status
);
   import dma_pkg::*;

   dma_state_e              state;
   logic [`DMA_LEN_W-1:0]   remaining;
   logic [`DMA_LEN_W-1:0]   cur_len;
   logic [`DMA_CNT_W-1:0]   done_cnt;
   logic [`PCIE_DATA_W-1:0] dword_total;

   // ************************************************************
   // transfer sequencer, one dword per clock.
   // ************************************************************
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         state       <= DMA_IDLE;
         remaining   <= '0;
         cur_len     <= '0;
         done_cnt    <= '0;
         dword_total <= '0;
      end else begin
         case (state)
            DMA_IDLE: begin
               if (start) begin
                  cur_len   <= desc.length;
                  remaining <= desc.length;
                  // an empty transfer goes straight to completion.
                  state     <= (desc.length == '0) ? DMA_DONE : DMA_BUSY;
               end
            end
            DMA_BUSY: begin
               remaining <= remaining - 1'b1;
               if (remaining == `DMA_LEN_W'(1)) begin
                  state <= DMA_DONE;
               end
            end
            DMA_DONE: begin
               if (done_cnt != '1) begin
                  done_cnt <= done_cnt + 1'b1;   // count holds at all ones.
               end
               dword_total <= dword_total + `PCIE_DATA_W'(cur_len);
               state       <= DMA_IDLE;
            end
            default: state <= DMA_IDLE;
         endcase
      end
   end

   always_comb begin
      status             = '0;
      status.busy        = (state == DMA_BUSY);
      status.state       = state;
      status.done_cnt    = done_cnt;
      status.dword_total = dword_total;
   end

endmodule

`default_nettype wire

// ==== hdl/dma_prg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module dma_prg_regs (
   input  logic                      clk_in,
   input  logic                      rstn,
   input  dma_pkg::prg_wr_t          prg,
   input  logic [`DMA_PRG_IDX_W-1:0] rd_word,
   output logic [`PCIE_DATA_W-1:0]   rddata,
   output dma_pkg::dma_desc_t        desc,
   output logic                      start
);
   import reg_map_pkg::*;

   logic [`PCIE_DATA_W-1:0] prg_mem [`DMA_PRG_WORDS];

   // ************************************************************
   // program words and registered read port.
   // ************************************************************
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         for (int i = 0; i < `DMA_PRG_WORDS; i++) begin
            prg_mem[i] <= '0;
         end
         rddata <= '0;
         start  <= 1'b0;
      end else begin
         if (prg.wrena) begin
            prg_mem[prg.word] <= prg.data;   // control word keeps bit 0 for readback.
         end
         rddata <= prg_mem[rd_word];
         start  <= prg.wrena && (prg.word == PRG_CONTROL) && prg.data[0];
      end
   end

   // the engine sees the descriptor as a level.
   assign desc.host_addr = {prg_mem[PRG_ADDR_HI], prg_mem[PRG_ADDR_LO]};
   assign desc.length    = prg_mem[PRG_LENGTH][`DMA_LEN_W-1:0];

endmodule

`default_nettype wire

// ==== hdl/ep_reg_access.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module ep_reg_access (
   input  logic                      clk_in,
   input  logic                      rstn,
   input  logic                      sel_ep_reg,
   input  logic                      reg_wr_ena,
   input  logic                      reg_rd_ena,
   input  logic [`PCIE_ADDR_W-1:0]   reg_wr_addr,
   input  logic [`PCIE_ADDR_W-1:0]   reg_rd_addr,
   input  logic [`PCIE_DATA_W-1:0]   reg_wr_data,
   input  logic [`PCIE_DATA_W-1:0]   wr_prg_rddata,
   input  logic [`PCIE_DATA_W-1:0]   rd_prg_rddata,
   input  dma_pkg::dma_status_t      wr_status,
   input  dma_pkg::dma_status_t      rd_status,
   input  logic [`DMA_CNT_W-1:0]     ecrc_bad_cnt,
   output dma_pkg::prg_wr_t          wr_prg,
   output dma_pkg::prg_wr_t          rd_prg,
   output logic [`DMA_PRG_IDX_W-1:0] prg_rd_word,
   output logic [`PCIE_DATA_W-1:0]   reg_rd_data,
   output logic                      reg_rd_data_valid
);
   import dma_pkg::*;
   import reg_map_pkg::*;

   logic                     wr_ena_q;
   logic                     rd_ena_q;
   logic [`PCIE_ADDR_W-1:0]  wr_addr_q;
   logic [`PCIE_ADDR_W-1:0]  rd_addr_q;
   logic [`PCIE_DATA_W-1:0]  wr_data_q;
   logic                     prg_rd_q2;
   logic                     prg_rd_q3;
   logic [`PCIE_DATA_W-1:0]  wr_prg_rddata_q;
   logic [`PCIE_DATA_W-1:0]  rd_prg_rddata_q;
   logic [`PCIE_DATA_W-1:0]  err_status_q;
   dma_status_t              wr_status_q;
   dma_status_t              rd_status_q;
   reg_region_e              wr_region;
   reg_region_e              rd_region;
   logic                     rd_is_prg;

   assign wr_region   = reg_region_e'(wr_addr_q[7:4]);
   assign rd_region   = reg_region_e'(rd_addr_q[7:4]);
   assign rd_is_prg   = (rd_region == REG_DMA_WRITE_PRG) || (rd_region == REG_DMA_READ_PRG);
   assign prg_rd_word = rd_addr_q[3:2];   // program files register this on the next edge.

   // ************************************************************
   // input stage and status sampling.
   // ************************************************************
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wr_ena_q        <= 1'b0;
         rd_ena_q        <= 1'b0;
         wr_addr_q       <= '0;
         rd_addr_q       <= '0;
         wr_data_q       <= '0;
         prg_rd_q2       <= 1'b0;
         prg_rd_q3       <= 1'b0;
         wr_prg_rddata_q <= '0;
         rd_prg_rddata_q <= '0;
         err_status_q    <= '0;
         wr_status_q     <= '0;
         rd_status_q     <= '0;
      end else begin
         wr_ena_q        <= reg_wr_ena & sel_ep_reg;
         rd_ena_q        <= reg_rd_ena & sel_ep_reg;
         wr_addr_q       <= reg_wr_addr;
         rd_addr_q       <= reg_rd_addr;
         wr_data_q       <= reg_wr_data;
         prg_rd_q2       <= rd_ena_q & rd_is_prg;   // only program reads take the long path.
         prg_rd_q3       <= prg_rd_q2;
         wr_prg_rddata_q <= wr_prg_rddata;
         rd_prg_rddata_q <= rd_prg_rddata;
         err_status_q    <= {{(`PCIE_DATA_W-`DMA_CNT_W){1'b0}}, ecrc_bad_cnt};
         wr_status_q     <= wr_status;
         rd_status_q     <= rd_status;
      end
   end

   // ************************************************************
   // program writes, read mux and valid.
   // ************************************************************
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wr_prg            <= '0;
         rd_prg            <= '0;
         reg_rd_data       <= '0;
         reg_rd_data_valid <= 1'b0;
      end else begin
         wr_prg.wrena <= wr_ena_q && (wr_region == REG_DMA_WRITE_PRG);
         wr_prg.word  <= wr_addr_q[3:2];
         wr_prg.data  <= wr_data_q;
         rd_prg.wrena <= wr_ena_q && (wr_region == REG_DMA_READ_PRG);
         rd_prg.word  <= wr_addr_q[3:2];
         rd_prg.data  <= wr_data_q;

         case (rd_region)
            REG_MISC: begin
               case (misc_offset_e'(rd_addr_q[3:0]))
                  WR_STATUS_HI: reg_rd_data <= wr_status_q[2*`PCIE_DATA_W-1:`PCIE_DATA_W];
                  WR_STATUS_LO: reg_rd_data <= wr_status_q[`PCIE_DATA_W-1:0];
                  RD_STATUS_HI: reg_rd_data <= rd_status_q[2*`PCIE_DATA_W-1:`PCIE_DATA_W];
                  RD_STATUS_LO: reg_rd_data <= rd_status_q[`PCIE_DATA_W-1:0];
                  default:      reg_rd_data <= '0;
               endcase
            end
            REG_ERR_STATUS:
               reg_rd_data <= (rd_addr_q[3:0] == 4'h0) ? err_status_q : '0;
            REG_DMA_WRITE_PRG:
               reg_rd_data <= (rd_addr_q[1:0] == 2'b00) ? wr_prg_rddata_q : '0;
            REG_DMA_READ_PRG:
               reg_rd_data <= (rd_addr_q[1:0] == 2'b00) ? rd_prg_rddata_q : '0;
            default:
               reg_rd_data <= '0;   // unmapped space reads zero.
         endcase

         reg_rd_data_valid <= rd_is_prg ? prg_rd_q3 : rd_ena_q;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/ep_dma_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module ep_dma_ctrl_top (
   input  logic                    clk_in,
   input  logic                    rstn,
   input  logic                    sel_ep_reg,
   input  logic                    reg_wr_ena,
   input  logic                    reg_rd_ena,
   input  logic [`PCIE_ADDR_W-1:0] reg_wr_addr,
   input  logic [`PCIE_ADDR_W-1:0] reg_rd_addr,
   input  logic [`PCIE_DATA_W-1:0] reg_wr_data,
   input  logic                    rx_ecrc_bad,
   output logic [`PCIE_DATA_W-1:0] reg_rd_data,
   output logic                    reg_rd_data_valid
);
   import dma_pkg::*;

   prg_wr_t                   wr_prg;
   prg_wr_t                   rd_prg;
   logic [`DMA_PRG_IDX_W-1:0] prg_rd_word;
   logic [`PCIE_DATA_W-1:0]   wr_prg_rddata;
   logic [`PCIE_DATA_W-1:0]   rd_prg_rddata;
   dma_desc_t                 wr_desc;
   dma_desc_t                 rd_desc;
   logic                      wr_start;
   logic                      rd_start;
   dma_status_t               wr_status;
   dma_status_t               rd_status;
   logic [`DMA_CNT_W-1:0]     ecrc_bad_cnt;

   // ************************************************************
   // host register access.
   // ************************************************************
   ep_reg_access u_reg_access (
      .clk_in            (clk_in),
      .rstn              (rstn),
      .sel_ep_reg        (sel_ep_reg),
      .reg_wr_ena        (reg_wr_ena),
      .reg_rd_ena        (reg_rd_ena),
      .reg_wr_addr       (reg_wr_addr),
      .reg_rd_addr       (reg_rd_addr),
      .reg_wr_data       (reg_wr_data),
      .wr_prg_rddata     (wr_prg_rddata),
      .rd_prg_rddata     (rd_prg_rddata),
      .wr_status         (wr_status),
      .rd_status         (rd_status),
      .ecrc_bad_cnt      (ecrc_bad_cnt),
      .wr_prg            (wr_prg),
      .rd_prg            (rd_prg),
      .prg_rd_word       (prg_rd_word),
      .reg_rd_data       (reg_rd_data),
      .reg_rd_data_valid (reg_rd_data_valid)
   );

   // ************************************************************
   // write channel.
   // ************************************************************
   dma_prg_regs u_wr_prg (
      .clk_in  (clk_in),
      .rstn    (rstn),
      .prg     (wr_prg),
      .rd_word (prg_rd_word),
      .rddata  (wr_prg_rddata),
      .desc    (wr_desc),
      .start   (wr_start)
   );

   dma_engine u_wr_dma (
      .clk_in (clk_in),
      .rstn   (rstn),
      .start  (wr_start),
      .desc   (wr_desc),
      .status (wr_status)
   );

   // ************************************************************
   // read channel.
   // ************************************************************
   dma_prg_regs u_rd_prg (
      .clk_in  (clk_in),
      .rstn    (rstn),
      .prg     (rd_prg),
      .rd_word (prg_rd_word),
      .rddata  (rd_prg_rddata),
      .desc    (rd_desc),
      .start   (rd_start)
   );

   dma_engine u_rd_dma (
      .clk_in (clk_in),
      .rstn   (rstn),
      .start  (rd_start),
      .desc   (rd_desc),
      .status (rd_status)
   );

   ecrc_err_counter u_ecrc_cnt (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .rx_ecrc_bad (rx_ecrc_bad),
      .bad_cnt     (ecrc_bad_cnt)
   );

endmodule

`default_nettype wire

// ==== tests/ep_dma_ctrl_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module ep_dma_ctrl_chk (
   input  logic                    clk_in,
   input  logic                    rstn,
   input  logic                    sel_ep_reg,
   input  logic                    reg_wr_ena,
   input  logic                    reg_rd_ena,
   input  logic [`PCIE_ADDR_W-1:0] reg_wr_addr,
   input  logic [`PCIE_ADDR_W-1:0] reg_rd_addr,
   input  dma_pkg::prg_wr_t        wr_prg,
   input  dma_pkg::prg_wr_t        rd_prg,
   input  logic                    reg_rd_data_valid
);
   import reg_map_pkg::*;

   int          wrena_fails = 0;
   int          pulse_fails = 0;
   int          misc_fails = 0;
   int          prg_fails = 0;
   int          assert_fails;
   reg_region_e wr_region;
   reg_region_e rd_region;
   logic        wr_req;
   logic        rd_req;

   assign wr_region    = reg_region_e'(reg_wr_addr[7:4]);
   assign rd_region    = reg_region_e'(reg_rd_addr[7:4]);
   assign wr_req       = sel_ep_reg && reg_wr_ena;   // a write the block accepts.
   assign rd_req       = sel_ep_reg && reg_rd_ena;   // a read the block accepts.
   assign assert_fails = wrena_fails + pulse_fails + misc_fails + prg_fails;

   // ************************************************************
   // control output rules.
   // ************************************************************

   // each write enable follows a host write to its own region, so the two never meet.
   a_wrena_region: assert property (@(posedge clk_in) disable iff (!rstn)
      (wr_prg.wrena == $past(wr_req && (wr_region == REG_DMA_WRITE_PRG), 2))
      && (rd_prg.wrena == $past(wr_req && (wr_region == REG_DMA_READ_PRG), 2)))
      else begin
         $error("program file write enable does not match the host write region");
         wrena_fails++;
      end

   a_valid_pulse: assert property (@(posedge clk_in) disable iff (!rstn)
      reg_rd_data_valid |=> !reg_rd_data_valid)
      else begin
         $error("read data valid stayed high for more than one cycle");
         pulse_fails++;
      end

   a_misc_latency: assert property (@(posedge clk_in) disable iff (!rstn)
      (rd_req && (rd_region == REG_MISC)) |-> ##1 !reg_rd_data_valid ##1 reg_rd_data_valid)
      else begin
         $error("read data valid did not rise two cycles after a MISC read");
         misc_fails++;
      end

   // program reads go through the program file and take the long path.
   a_prg_latency: assert property (@(posedge clk_in) disable iff (!rstn)
      (rd_req && ((rd_region == REG_DMA_WRITE_PRG) || (rd_region == REG_DMA_READ_PRG)))
      |-> ##1 !reg_rd_data_valid ##1 !reg_rd_data_valid ##1 !reg_rd_data_valid
          ##1 reg_rd_data_valid)
      else begin
         $error("read data valid did not rise four cycles after a program read");
         prg_fails++;
      end

endmodule

bind ep_reg_access ep_dma_ctrl_chk u_chk (
   .clk_in            (clk_in),
   .rstn              (rstn),
   .sel_ep_reg        (sel_ep_reg),
   .reg_wr_ena        (reg_wr_ena),
   .reg_rd_ena        (reg_rd_ena),
   .reg_wr_addr       (reg_wr_addr),
   .reg_rd_addr       (reg_rd_addr),
   .wr_prg            (wr_prg),
   .rd_prg            (rd_prg),
   .reg_rd_data_valid (reg_rd_data_valid)
);

`default_nettype wire

// ==== tests/ep_dma_ctrl_mon.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module ep_dma_ctrl_mon (
   input  logic                    clk_in,
   input  logic                    rstn,
   input  logic [`PCIE_DATA_W-1:0] reg_rd_data,
   input  logic                    reg_rd_data_valid,
   input  logic                    exp_arm,
   input  logic [`PCIE_DATA_W-1:0] exp_data,
   input  logic [8*16-1:0]         exp_name,
   output int                      err_cnt,
   output int                      check_cnt
);

   logic                    pending;
   logic [`PCIE_DATA_W-1:0] exp_q;
   logic [8*16-1:0]         name_q;

   // ************************************************************
   // one expected value is held per outstanding read.
   // ************************************************************
   always @(posedge clk_in) begin
      if (!rstn) begin
         pending = 1'b0;
         exp_q   = '0;
         name_q  = '0;
      end else begin
         if (reg_rd_data_valid) begin
            if (!pending) begin
               err_cnt++;
               $display("ERROR: read data valid came with no read outstanding, data %08h",
                        reg_rd_data);
            end else begin
               check_cnt++;
               pending = 1'b0;
               if (reg_rd_data !== exp_q) begin
                  err_cnt++;
                  $display("MISMATCH %0s: expected %08h, actual %08h",
                           name_q, exp_q, reg_rd_data);
               end
            end
         end
         if (exp_arm) begin
            pending = 1'b1;   // the read was just issued.
            exp_q   = exp_data;
            name_q  = exp_name;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/ep_dma_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_dma_cfg.svh"

module ep_dma_ctrl_tb;

   typedef enum logic [2:0] {
      OP_WRITE, OP_WRITE_NOSEL, OP_READ, OP_READ_NOSEL, OP_WAIT, OP_ECRC
   } op_e;

   typedef struct packed {
      logic [8*16-1:0]         name;
      op_e                     op;
      logic [`PCIE_ADDR_W-1:0] addr;
      logic [`PCIE_DATA_W-1:0] data;   // write data, or the count of a wait or ecrc step.
      logic [`PCIE_DATA_W-1:0] exp;
   } step_t;

   localparam int READ_TIMEOUT = 20;

   logic                    clk_in = 1'b0;
   logic                    rstn;
   logic                    sel_ep_reg;
   logic                    reg_wr_ena;
   logic                    reg_rd_ena;
   logic [`PCIE_ADDR_W-1:0] reg_wr_addr;
   logic [`PCIE_ADDR_W-1:0] reg_rd_addr;
   logic [`PCIE_DATA_W-1:0] reg_wr_data;
   logic                    rx_ecrc_bad;
   logic [`PCIE_DATA_W-1:0] reg_rd_data;
   logic                    reg_rd_data_valid;
   logic                    exp_arm;
   logic [`PCIE_DATA_W-1:0] exp_data;
   logic [8*16-1:0]         exp_name;
   step_t                   steps[$];
   logic [`PCIE_DATA_W-1:0] rnd [8];
   integer                  seed = 3842;
   int                      tb_errors = 0;
   int                      mon_errors;
   int                      mon_checks;
   int                      max_wait = 0;
   int                      watchdog_cycles = 0;

   always #10 clk_in = ~clk_in;

   ep_dma_ctrl_top DUT (.*);

   ep_dma_ctrl_mon u_mon (
      .clk_in (clk_in), .rstn (rstn), .reg_rd_data (reg_rd_data),
      .reg_rd_data_valid (reg_rd_data_valid), .exp_arm (exp_arm), .exp_data (exp_data),
      .exp_name (exp_name), .err_cnt (mon_errors), .check_cnt (mon_checks)
   );

   // high status word: busy, state, zero padding, completed count.
   function automatic logic [31:0] status_hi(input logic busy, input logic [1:0] state,
                                             input logic [15:0] cnt);
      return {busy, state, 13'd0, cnt};
   endfunction

   function automatic void add_step(input logic [8*16-1:0] name, input op_e op,
                                    input logic [7:0] addr, input logic [31:0] data,
                                    input logic [31:0] exp);
      step_t s;
      s.name = name;
      s.op   = op;
      s.addr = addr;
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
      if ((op == OP_WAIT) && (int'(data) > max_wait)) max_wait = int'(data);
   endfunction

   // ************************************************************
   // stimulus table.
   // ************************************************************
   function automatic void build_table();
      for (int i = 0; i < 8; i++) rnd[i] = $random(seed);
      rnd[3] = rnd[3] & 32'hFFFF_FFFE;   // control words must not start a channel.
      rnd[7] = rnd[7] & 32'hFFFF_FFFE;
      add_step("reset_status", OP_READ, 8'h20, '0, 32'h0);
      for (int i = 0; i < 8; i++) add_step("prg_write", OP_WRITE, 8'(i * 4), rnd[i], '0);
      for (int i = 0; i < 8; i++) add_step("prg_readback", OP_READ, 8'(i * 4), '0, rnd[i]);
      add_step("nosel_write", OP_WRITE_NOSEL, 8'h04, ~rnd[1], '0);
      add_step("nosel_keep", OP_READ, 8'h04, '0, rnd[1]);
      add_step("nosel_read", OP_READ_NOSEL, 8'h24, '0, '0);
      add_step("nosel_read", OP_READ_NOSEL, 8'h14, '0, '0);
      add_step("run_len", OP_WRITE, 8'h08, 32'd5, '0);
      add_step("run_len", OP_WRITE, 8'h18, 32'd0, '0);
      add_step("run_start", OP_WRITE, 8'h0C, 32'd1, '0);
      add_step("run_start", OP_WRITE, 8'h1C, 32'd1, '0);
      add_step("run_wait", OP_WAIT, '0, 32'd20, '0);
      add_step("wr_status_hi", OP_READ, 8'h20, '0, status_hi(1'b0, 2'd0, 16'd1));
      add_step("wr_status_lo", OP_READ, 8'h24, '0, 32'd5);
      add_step("rd_status_hi", OP_READ, 8'h28, '0, status_hi(1'b0, 2'd0, 16'd1));
      add_step("rd_status_lo", OP_READ, 8'h2C, '0, 32'd0);
      add_step("ctrl_readback", OP_READ, 8'h0C, '0, 32'd1);
      add_step("busy_len", OP_WRITE, 8'h08, 32'd40, '0);
      add_step("busy_start", OP_WRITE, 8'h0C, 32'd1, '0);
      add_step("busy_start", OP_WRITE, 8'h0C, 32'd1, '0);
      add_step("busy_wait", OP_WAIT, '0, 32'd4, '0);
      add_step("busy_status", OP_READ, 8'h20, '0, status_hi(1'b1, 2'd1, 16'd1));
      add_step("busy_wait", OP_WAIT, '0, 32'd60, '0);
      add_step("busy_count", OP_READ, 8'h20, '0, status_hi(1'b0, 2'd0, 16'd2));
      add_step("busy_total", OP_READ, 8'h24, '0, 32'd45);
      add_step("ecrc_pulses", OP_ECRC, '0, 32'd7, '0);
      add_step("ecrc_count", OP_READ, 8'h30, '0, 32'd7);
      add_step("misc_wr_ignored", OP_WRITE, 8'h20, rnd[0], '0);
      add_step("misc_wr_ignored", OP_READ, 8'h20, '0, status_hi(1'b0, 2'd0, 16'd2));
      add_step("unmapped_zero", OP_READ, 8'h40, '0, 32'h0);
      add_step("unmapped_zero", OP_READ, 8'hF8, '0, 32'h0);
      add_step("misc_odd_zero", OP_READ, 8'h21, '0, 32'h0);
      add_step("misc_odd_zero", OP_READ, 8'h2D, '0, 32'h0);
      add_step("err_odd_zero", OP_READ, 8'h34, '0, 32'h0);
      add_step("prg_odd_zero", OP_READ, 8'h03, '0, 32'h0);
   endfunction

   task automatic idle_drive();
      sel_ep_reg  <= 1'b1;
      reg_wr_ena  <= 1'b0;
      reg_rd_ena  <= 1'b0;
      rx_ecrc_bad <= 1'b0;
      exp_arm     <= 1'b0;
   endtask

   task automatic run_step(input step_t s);
      int n;
      @(posedge clk_in);
      idle_drive();
      case (s.op)
         OP_WRITE, OP_WRITE_NOSEL: begin
            sel_ep_reg  <= (s.op == OP_WRITE);
            reg_wr_ena  <= 1'b1;   // the next step drops it, so writes can run back to back.
            reg_wr_addr <= s.addr;
            reg_wr_data <= s.data;
         end
         OP_READ: begin
            reg_rd_ena  <= 1'b1;
            reg_rd_addr <= s.addr;
            exp_arm     <= 1'b1;
            exp_data    <= s.exp;
            exp_name    <= s.name;
            @(posedge clk_in);
            idle_drive();
            n = 0;
            while (!reg_rd_data_valid && (n < READ_TIMEOUT)) begin
               @(posedge clk_in);
               n++;
            end
            if (!reg_rd_data_valid) begin
               tb_errors++;
               $display("ERROR: read %0s at address %02h, valid never came", s.name, s.addr);
            end
         end
         OP_READ_NOSEL: begin
            sel_ep_reg  <= 1'b0;
            reg_rd_ena  <= 1'b1;
            reg_rd_addr <= s.addr;
            @(posedge clk_in);
            idle_drive();
            repeat (8) @(posedge clk_in);   // the monitor flags any valid in this window.
         end
         OP_WAIT: repeat (s.data) @(posedge clk_in);
         OP_ECRC: begin
            for (int i = 0; i < int'(s.data); i++) begin
               rx_ecrc_bad <= 1'b1;
               @(posedge clk_in);
               rx_ecrc_bad <= 1'b0;
               @(posedge clk_in);
            end
         end
         default: ;
      endcase
   endtask

   initial begin
      int total;
      rstn        = 1'b0;
      sel_ep_reg  = 1'b0;
      reg_wr_ena  = 1'b0;
      reg_rd_ena  = 1'b0;
      reg_wr_addr = '0;
      reg_rd_addr = '0;
      reg_wr_data = '0;
      rx_ecrc_bad = 1'b0;
      exp_arm     = 1'b0;
      exp_data    = '0;
      exp_name    = '0;
      build_table();
      watchdog_cycles = steps.size() * (max_wait + 40) + 100;
      repeat (10) @(posedge clk_in);
      rstn <= 1'b1;
      foreach (steps[i]) run_step(steps[i]);
      @(posedge clk_in);
      idle_drive();
      repeat (8) @(posedge clk_in);
      total = tb_errors + mon_errors + DUT.u_reg_access.u_chk.assert_fails;
      $display("closing report: %0d reads checked, %0d errors", mon_checks, total);
      if (total == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // ************************************************************
   // watchdog.
   // ************************************************************
   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk_in);
      $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
               watchdog_cycles);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ep_dma_ctrl_top.f ====
+incdir+hdl
hdl/reg_map_pkg.sv
hdl/dma_pkg.sv
hdl/ecrc_err_counter.sv
hdl/dma_engine.sv
hdl/dma_prg_regs.sv
hdl/ep_reg_access.sv
hdl/ep_dma_ctrl_top.sv
tests/ep_dma_ctrl_chk.sv
tests/ep_dma_ctrl_mon.sv
tests/ep_dma_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, the full output goes to sim.log.
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

{ verilator --binary --assert --timing --top-module ep_dma_ctrl_tb \
     -f ep_dma_ctrl_top.f -o ep_dma_ctrl_sim \
  && ./obj_dir/ep_dma_ctrl_sim +verilator+error+limit+1000; } > "$log" 2>&1 \
  || echo "tests failed: build or simulation returned an error" >> "$log"

cat "$log"
grep -q "tests failed" "$log" && { echo "RESULT: FAIL"; exit 1; } || { echo "RESULT: PASS"; exit 0; }
